// File: vlog.f
logic/gpu_geom_pkg.sv
logic/gpu_bus_pkg.sv
logic/fb_arbiter.sv
logic/fb_clear.sv
logic/depth_write.sv
logic/triangle_raster.sv
logic/gpu_control.sv
logic/gpu_core.sv
dv/tb_gpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_gpu_core
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_gpu_core.sv
`timescale 1ns/1ns

module tb_gpu_core import gpu_geom_pkg::*, gpu_bus_pkg::*; ();

  localparam int clk_period = 40;
  // worst frame is a full clear plus every box pixel held four cycles in the depth unit
  localparam int frame_cycles = fb_words + max_tris * (tri_words + screen_w * screen_h * 4);
  localparam int readback_cycles = fb_words * 8;
  localparam int num_frames = 8;
  localparam int watchdog_ns =
    (num_frames * (frame_cycles + readback_cycles) + 20000) * clk_period;

  logic gpu_clk = 1'b0;
  logic rst_in;
  logic awvalid;
  logic awready;
  logic [axi_addr_w-1:0] awaddr;
  logic wvalid;
  logic wready;
  logic [axi_data_w-1:0] wdata;
  logic [axi_data_w/8-1:0] wstrb;
  logic bvalid;
  logic bready;
  logic [1:0] bresp;
  logic arvalid;
  logic arready;
  logic [axi_addr_w-1:0] araddr;
  logic rvalid;
  logic rready;
  logic [axi_data_w-1:0] rdata;
  logic [1:0] rresp;

  logic [axi_data_w-1:0] tri_img [max_tris*tri_words];
  fb_word_t model_fb [fb_words];
  logic [31:0] lfsr_state = 32'h02334f99;
  int errors = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int exp_frames = 0;
  int start_errs;

  gpu_core dut_i (
    .gpu_clk, .rst_in,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp
  );

  always #(clk_period / 2) gpu_clk = ~gpu_clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int edge_val(input int ax, ay, bx, by, qx, qy);
    return (bx - ax) * (qy - ay) - (by - ay) * (qx - ax);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic axi_write(input logic [axi_addr_w-1:0] addr,
                           input logic [axi_data_w-1:0] data);
    @(negedge gpu_clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge gpu_clk);
      #1;
    end
    // handshake lands on the rising edge ahead
    @(negedge gpu_clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!bvalid) @(negedge gpu_clk);
    check_value("bresp", bresp, 2'b00);
  endtask

  task automatic axi_read(input logic [axi_addr_w-1:0] addr,
                          output logic [axi_data_w-1:0] data);
    @(negedge gpu_clk);
    araddr = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge gpu_clk);
      #1;
    end
    @(negedge gpu_clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge gpu_clk);
    data = rdata;
    check_value("rresp", rresp, 2'b00);
  endtask

  task automatic check_reg(input logic [axi_addr_w-1:0] addr, input logic [31:0] exp,
                           input string what);
    logic [31:0] got;
    axi_read(addr, got);
    check_value(what, got, exp);
  endtask

  task automatic wait_frame();
    logic [31:0] st;
    st = 32'h1;
    while (st[0]) axi_read(status_reg, st);
  endtask

  task automatic write_tri_word(input int idx, input logic [31:0] word);
    tri_img[idx] = word;
    axi_write(tri_mem_base + axi_addr_w'(idx * 4), word);
  endtask

  task automatic load_triangle(input int t, input int x0, y0, x1, y1, x2, y2,
                               input logic [z_w-1:0] z, input logic [rgb_w-1:0] rgb);
    write_tri_word(t * tri_words, {13'b0, z, 5'(y0), 6'(x0)});
    write_tri_word(t * tri_words + 1, {13'b0, z, 5'(y1), 6'(x1)});
    write_tri_word(t * tri_words + 2, {13'b0, z, 5'(y2), 6'(x2)});
    write_tri_word(t * tri_words + 3, {20'b0, rgb});
  endtask

  // clear, then every triangle in draw order with the first vertex depth
  task automatic model_frame(input logic [rgb_w-1:0] bg, input int ntri, output int passes);
    int vx [3];
    int vy [3];
    int x_lo, x_hi, y_lo, y_hi;
    int e0, e1, e2;
    int addr;
    logic [z_w-1:0] z;
    logic [rgb_w-1:0] rgb;
    passes = 0;
    for (int a = 0; a < fb_words; a++) model_fb[a] = {z_far, bg};
    for (int t = 0; t < ntri; t++) begin
      for (int v = 0; v < 3; v++) begin
        vx[v] = $signed(tri_img[t * tri_words + v][5:0]);
        vy[v] = $signed(tri_img[t * tri_words + v][10:6]);
      end
      z = tri_img[t * tri_words][18:11];
      rgb = tri_img[t * tri_words + 3][rgb_w-1:0];
      if (edge_val(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]) == 0) continue;
      x_lo = vx[0];
      x_hi = vx[0];
      y_lo = vy[0];
      y_hi = vy[0];
      for (int v = 1; v < 3; v++) begin
        x_lo = (vx[v] < x_lo) ? vx[v] : x_lo;
        x_hi = (vx[v] > x_hi) ? vx[v] : x_hi;
        y_lo = (vy[v] < y_lo) ? vy[v] : y_lo;
        y_hi = (vy[v] > y_hi) ? vy[v] : y_hi;
      end
      x_lo = (x_lo < 0) ? 0 : x_lo;
      y_lo = (y_lo < 0) ? 0 : y_lo;
      x_hi = (x_hi > screen_w - 1) ? screen_w - 1 : x_hi;
      y_hi = (y_hi > screen_h - 1) ? screen_h - 1 : y_hi;
      for (int y = y_lo; y <= y_hi; y++) begin
        for (int x = x_lo; x <= x_hi; x++) begin
          e0 = edge_val(vx[0], vy[0], vx[1], vy[1], x, y);
          e1 = edge_val(vx[1], vy[1], vx[2], vy[2], x, y);
          e2 = edge_val(vx[2], vy[2], vx[0], vy[0], x, y);
          if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0)) begin
            addr = y * screen_w + x;
            if (z < model_fb[addr].z) begin
              model_fb[addr] = {z, rgb};
              passes++;
            end
          end
        end
      end
    end
  endtask

  task automatic check_framebuffer();
    logic [31:0] got;
    int bad;
    bad = 0;
    for (int a = 0; a < fb_words; a++) begin
      axi_read(fb_base + axi_addr_w'(a * 4), got);
      assert (got === {12'b0, model_fb[a]}) else begin
        bad++;
        errors++;
        if (bad <= 4) begin
          $display("[ERROR] %0t ns: framebuffer word %0d is 0x%0h, expected 0x%0h",
                   $time, a, got, {12'b0, model_fb[a]});
        end
      end
    end
  endtask

  task automatic run_frame(input logic [rgb_w-1:0] bg, input int ntri, input bit restart);
    int passes;
    axi_write(bg_color_reg, bg);
    axi_write(tri_count_reg, ntri);
    axi_write(ctrl_reg, 32'h3);
    // second start lands while the clear is still running
    if (restart) axi_write(ctrl_reg, 32'h3);
    exp_frames++;
    wait_frame();
    model_frame(bg, ntri, passes);
    check_reg(frame_count_reg, exp_frames, "frame_count");
    check_reg(pixel_count_reg, passes, "pixel_count");
    check_framebuffer();
  endtask

  task automatic check_pixel(input int x, y, input logic [z_w-1:0] z,
                             input logic [rgb_w-1:0] rgb);
    check_reg(fb_base + axi_addr_w'((y * screen_w + x) * 4), {12'b0, z, rgb}, "overlap pixel");
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_bad++;
      $display("test %s: %0d check(s) wrong", name, errors - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic test_reset_values();
    check_value("bvalid", bvalid, 0);
    check_value("rvalid", rvalid, 0);
    check_reg(status_reg, 0, "status");
    check_reg(frame_count_reg, 0, "frame_count");
    check_reg(pixel_count_reg, 0, "pixel_count");
  endtask

  task automatic test_registers();
    logic [31:0] got;
    axi_write(bg_color_reg, 32'h0000_fabc);
    check_reg(bg_color_reg, 32'habc, "bg_color");
    axi_write(tri_count_reg, 5);
    check_reg(tri_count_reg, 5, "tri_count");
    axi_write(tri_count_reg, 40);
    check_reg(tri_count_reg, max_tris, "clamped tri_count");
    axi_write(ctrl_reg, 32'h2);
    check_reg(ctrl_reg, 32'h2, "ctrl");
    for (int i = 0; i < max_tris * tri_words; i++) write_tri_word(i, lfsr_bits(32));
    for (int i = 0; i < max_tris * tri_words; i++) begin
      axi_read(tri_mem_base + axi_addr_w'(i * 4), got);
      check_value("triangle memory word", got, tri_img[i]);
    end
    axi_write(12'h020, 32'hdead_beef);
    check_reg(12'h020, 0, "unmapped address");
  endtask

  task automatic test_windings();
    load_triangle(0, 2, 2, 12, 2, 2, 10, 8'd100, 12'h0f0);
    run_frame(12'h111, 1, 1'b0);
    load_triangle(0, 2, 2, 2, 10, 12, 2, 8'd100, 12'h0f0);
    run_frame(12'h111, 1, 1'b0);
    // all three vertices on one line
    load_triangle(0, 3, 3, 6, 6, 9, 9, 8'd40, 12'hf00);
    run_frame(12'h222, 1, 1'b0);
    check_reg(pixel_count_reg, 0, "zero-area pixel_count");
  endtask

  task automatic test_overlap();
    load_triangle(0, 0, 0, 20, 0, 0, 14, 8'd200, 12'h00f);
    load_triangle(1, 4, 4, 24, 4, 4, 15, 8'd50, 12'hf0f);
    run_frame(12'h000, 2, 1'b0);
    check_pixel(6, 6, 8'd50, 12'hf0f);
    load_triangle(0, 4, 4, 24, 4, 4, 15, 8'd50, 12'hf0f);
    load_triangle(1, 0, 0, 20, 0, 0, 14, 8'd200, 12'h00f);
    run_frame(12'h000, 2, 1'b1);
    check_pixel(6, 6, 8'd50, 12'hf0f);
  endtask

  task automatic test_random_tris();
    for (int t = 0; t < max_tris; t++) begin
      for (int v = 0; v < 3; v++) write_tri_word(t * tri_words + v, lfsr_bits(19));
      write_tri_word(t * tri_words + 3, lfsr_bits(12));
    end
    run_frame(lfsr_bits(12), max_tris, 1'b0);
  endtask

  initial begin
    rst_in = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = 4'hf;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b1;
    repeat (3) @(negedge gpu_clk);
    rst_in = 1'b0;

    start_errs = errors;
    test_reset_values();
    report_test("reset values", start_errs);
    start_errs = errors;
    test_registers();
    report_test("register access", start_errs);
    start_errs = errors;
    run_frame(12'h3c5, 0, 1'b0);
    report_test("clear only", start_errs);
    start_errs = errors;
    test_windings();
    report_test("windings", start_errs);
    start_errs = errors;
    test_overlap();
    report_test("depth overlap", start_errs);
    start_errs = errors;
    test_random_tris();
    report_test("random triangles", start_errs);

    $display("%0d tests run, %0d failed, %0d checks wrong", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired, the tests did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: logic/gpu_core.sv
`timescale 1ns/1ns

module gpu_core import gpu_geom_pkg::*, gpu_bus_pkg::*; (
  input  logic gpu_clk,
  input  logic rst_in,
  input  logic awvalid,
  output logic awready,
  input  logic [axi_addr_w-1:0] awaddr,
  input  logic wvalid,
  output logic wready,
  input  logic [axi_data_w-1:0] wdata,
  input  logic [axi_data_w/8-1:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [1:0] bresp,
  input  logic arvalid,
  output logic arready,
  input  logic [axi_addr_w-1:0] araddr,
  output logic rvalid,
  input  logic rready,
  output logic [axi_data_w-1:0] rdata,
  output logic [1:0] rresp
);

  logic [tri_addr_w-1:0] tri_rd_addr;
  logic [tri_word_w-1:0] tri_rd_data;
  logic [tri_cnt_w-1:0] tri_count;
  logic [rgb_w-1:0] bg_color;
  logic clear_start;
  logic clear_done;
  logic raster_start;
  logic raster_done;
  logic depth_idle;
  logic [count_w-1:0] pass_count;

  // fragment stream
  logic frag_valid;
  logic frag_ready;
  frag_t frag_data;

  // framebuffer requesters
  logic host_req;
  logic host_gnt;
  logic [fb_addr_w-1:0] host_addr;
  logic clr_req;
  logic clr_gnt;
  logic [fb_addr_w-1:0] clr_addr;
  fb_word_t clr_wdata;
  logic dw_req;
  logic dw_gnt;
  logic dw_we;
  logic [fb_addr_w-1:0] dw_addr;
  fb_word_t dw_wdata;
  fb_word_t fb_rd_data;

  gpu_control control_i (
    .gpu_clk, .rst_in,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp,
    .tri_rd_addr, .tri_rd_data, .tri_count, .bg_color,
    .clear_start, .clear_done, .raster_start, .raster_done,
    .depth_idle, .pass_count,
    .host_req, .host_addr, .host_gnt, .fb_rd_data
  );

  triangle_raster raster_i (
    .gpu_clk, .rst_in,
    .raster_start, .tri_count, .tri_rd_data, .frag_ready,
    .raster_done, .tri_rd_addr, .frag_valid, .frag_data
  );

  depth_write depth_i (
    .gpu_clk, .rst_in,
    .frame_start(raster_start),
    .frag_valid, .frag_data, .dw_gnt, .fb_rd_data,
    .frag_ready, .depth_idle, .pass_count,
    .dw_req, .dw_we, .dw_addr, .dw_wdata
  );

  fb_clear clear_i (
    .gpu_clk, .rst_in,
    .clear_start, .bg_color, .clr_gnt,
    .clear_done, .clr_req, .clr_addr, .clr_wdata
  );

  fb_arbiter arbiter_i (
    .gpu_clk, .rst_in,
    .clr_req, .clr_addr, .clr_wdata,
    .dw_req, .dw_we, .dw_addr, .dw_wdata,
    .host_req, .host_addr,
    .clr_gnt, .dw_gnt, .host_gnt, .fb_rd_data
  );

endmodule

// File: logic/gpu_control.sv
`timescale 1ns/1ns

module gpu_control import gpu_geom_pkg::*, gpu_bus_pkg::*; (
  input  logic gpu_clk,
  input  logic rst_in,
  input  logic awvalid,
  output logic awready,
  input  logic [axi_addr_w-1:0] awaddr,
  input  logic wvalid,
  output logic wready,
  input  logic [axi_data_w-1:0] wdata,
  input  logic [axi_data_w/8-1:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [1:0] bresp,
  input  logic arvalid,
  output logic arready,
  input  logic [axi_addr_w-1:0] araddr,
  output logic rvalid,
  input  logic rready,
  output logic [axi_data_w-1:0] rdata,
  output logic [1:0] rresp,
  input  logic [tri_addr_w-1:0] tri_rd_addr,
  output logic [tri_word_w-1:0] tri_rd_data,
  output logic [tri_cnt_w-1:0] tri_count,
  output logic [rgb_w-1:0] bg_color,
  output logic clear_start,
  input  logic clear_done,
  output logic raster_start,
  input  logic raster_done,
  input  logic depth_idle,
  input  logic [count_w-1:0] pass_count,
  output logic host_req,
  output logic [fb_addr_w-1:0] host_addr,
  input  logic host_gnt,
  input  fb_word_t fb_rd_data
);

  typedef enum logic [1:0] {st_idle, st_clear, st_raster, st_drain} frame_state_t;

  frame_state_t state;
  logic [tri_word_w-1:0] tri_mem [max_tris*tri_words];
  logic [count_w-1:0] frame_count;
  logic [count_w-1:0] pixel_count;
  logic [axi_data_w-1:0] reg_rdata;
  logic clear_en;
  logic fb_wait;
  logic wr_hs;
  logic start_req;

  assign wr_hs = awvalid && wvalid && !bvalid;
  assign awready = wr_hs;
  assign wready = wr_hs;
  assign bresp = resp_okay;
  assign rresp = resp_okay;
  // one read in flight, including a framebuffer read waiting on the arbiter
  assign arready = arvalid && !rvalid && !host_req && !fb_wait;
  assign start_req = wr_hs && awaddr == ctrl_reg && wdata[0] && state == st_idle;

  always_comb begin
    reg_rdata = '0;
    case (araddr)
      ctrl_reg: reg_rdata[1] = clear_en;
      status_reg: reg_rdata[0] = state != st_idle;
      tri_count_reg: reg_rdata[tri_cnt_w-1:0] = tri_count;
      bg_color_reg: reg_rdata[rgb_w-1:0] = bg_color;
      frame_count_reg: reg_rdata[count_w-1:0] = frame_count;
      pixel_count_reg: reg_rdata[count_w-1:0] = pixel_count;
      default: begin
        if ((araddr & ~tri_win_mask) == tri_mem_base) begin
          reg_rdata = tri_mem[araddr[tri_addr_w+1:2]];
        end
      end
    endcase
  end

  // host port and raster port of the triangle memory
  always_ff @(posedge gpu_clk) begin
    if (wr_hs && (awaddr & ~tri_win_mask) == tri_mem_base) begin
      tri_mem[awaddr[tri_addr_w+1:2]] <= wdata;
    end
    tri_rd_data <= tri_mem[tri_rd_addr];
  end

  always_ff @(posedge gpu_clk) begin
    if (arready) begin
      rdata <= reg_rdata;
      host_addr <= araddr[fb_addr_w+1:2];
    end else if (fb_wait) begin
      rdata <= axi_data_w'(fb_rd_data);
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      host_req <= 1'b0;
      fb_wait <= 1'b0;
      clear_en <= 1'b0;
      tri_count <= '0;
      bg_color <= '0;
      clear_start <= 1'b0;
      raster_start <= 1'b0;
      frame_count <= '0;
      pixel_count <= '0;
      state <= st_idle;
    end else begin
      clear_start <= 1'b0;
      raster_start <= 1'b0;

      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (wr_hs) begin
        case (awaddr)
          ctrl_reg: clear_en <= wdata[1];
          tri_count_reg: begin
            tri_count <= (wdata > max_tris) ? tri_cnt_w'(max_tris) : wdata[tri_cnt_w-1:0];
          end
          bg_color_reg: bg_color <= wdata[rgb_w-1:0];
          default: ;
        endcase
      end

      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (arready) begin
        if ((araddr & ~fb_win_mask) == fb_base) begin
          host_req <= 1'b1;
        end else begin
          rvalid <= 1'b1;
        end
      end
      if (host_req && host_gnt) begin
        host_req <= 1'b0;
        fb_wait <= 1'b1;
      end
      if (fb_wait) begin
        fb_wait <= 1'b0;
        rvalid <= 1'b1;
      end

      // frame sequencer
      case (state)
        st_idle: begin
          if (start_req && wdata[1]) begin
            clear_start <= 1'b1;
            state <= st_clear;
          end else if (start_req) begin
            raster_start <= 1'b1;
            state <= st_raster;
          end
        end
        st_clear: begin
          if (clear_done) begin
            raster_start <= 1'b1;
            state <= st_raster;
          end
        end
        st_raster: begin
          if (raster_done) begin
            state <= st_drain;
          end
        end
        default: begin
          if (depth_idle) begin
            frame_count <= frame_count + 1'b1;
            pixel_count <= pass_count;
            state <= st_idle;
          end
        end
      endcase
    end
  end

  assert property (@(posedge gpu_clk) disable iff (rst_in)
    awvalid && !awready |=> $stable(awaddr));

  // byte strobes are not decoded
  assert property (@(posedge gpu_clk) disable iff (rst_in) wr_hs |-> &wstrb);

endmodule

// File: logic/triangle_raster.sv
`timescale 1ns/1ns

module triangle_raster import gpu_geom_pkg::*; (
  input  logic gpu_clk,
  input  logic rst_in,
  input  logic raster_start,
  input  logic [tri_cnt_w-1:0] tri_count,
  input  logic [tri_word_w-1:0] tri_rd_data,
  input  logic frag_ready,
  output logic raster_done,
  output logic [tri_addr_w-1:0] tri_rd_addr,
  output logic frag_valid,
  output frag_t frag_data
);

  localparam int px_w = $clog2(screen_w);
  localparam int py_w = $clog2(screen_h);
  localparam int idx_w = $clog2(max_tris);

  typedef enum logic [1:0] {st_idle, st_fetch, st_scan} rast_state_t;

  rast_state_t state;
  logic [idx_w-1:0] tri_idx;
  logic [idx_w-1:0] next_idx;
  logic [1:0] word_cnt;
  logic signed [x_w-1:0] vx [3];
  logic signed [y_w-1:0] vy [3];
  logic [z_w-1:0] z0;
  logic [rgb_w-1:0] color;
  logic [px_w-1:0] px, bx_min, bx_max;
  logic [py_w-1:0] py, by_min, by_max;
  logic signed [7:0] x_lo, x_hi, y_lo, y_hi;
  logic signed [15:0] e0, e1, e2, area;
  logic covered, box_empty, step, tri_end, last_tri;

  // E(a, b, p) = (b.x - a.x)(p.y - a.y) - (b.y - a.y)(p.x - a.x)
  function automatic logic signed [15:0] edge_fn(
    input logic signed [15:0] ax, ay, bx, by, qx, qy);
    return (bx - ax) * (qy - ay) - (by - ay) * (qx - ax);
  endfunction

  always_comb begin
    x_lo = vx[0];
    x_hi = vx[0];
    y_lo = vy[0];
    y_hi = vy[0];
    for (int i = 1; i < 3; i++) begin
      if (vx[i] < x_lo) x_lo = vx[i];
      if (vx[i] > x_hi) x_hi = vx[i];
      if (vy[i] < y_lo) y_lo = vy[i];
      if (vy[i] > y_hi) y_hi = vy[i];
    end
  end

  assign box_empty = x_hi < 0 || x_lo > screen_w - 1 || y_hi < 0 || y_lo > screen_h - 1;
  assign area = edge_fn(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]);

  assign e0 = edge_fn(vx[0], vy[0], vx[1], vy[1], $signed({1'b0, px}), $signed({1'b0, py}));
  assign e1 = edge_fn(vx[1], vy[1], vx[2], vy[2], $signed({1'b0, px}), $signed({1'b0, py}));
  assign e2 = edge_fn(vx[2], vy[2], vx[0], vy[0], $signed({1'b0, px}), $signed({1'b0, py}));
  // either winding counts as covered
  assign covered = (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);

  assign frag_valid = state == st_scan && covered;
  assign frag_data = {px, py, z0, color};
  assign step = !covered || frag_ready;

  assign tri_end = (state == st_fetch && word_cnt == 2'd3 && (area == 0 || box_empty))
    || (state == st_scan && step && px == bx_max && py == by_max);
  assign last_tri = {1'b0, tri_idx} == tri_count - 1'b1;

  // word 0 of the next record goes out one cycle before its fetch starts
  assign next_idx = (state == st_idle) ? '0 : tri_idx + 1'b1;
  assign tri_rd_addr = (state == st_fetch && word_cnt != 2'd3) ?
    {tri_idx, word_cnt + 2'd1} : {next_idx, 2'd0};

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      state <= st_idle;
      tri_idx <= '0;
      word_cnt <= '0;
      raster_done <= 1'b0;
    end else begin
      raster_done <= 1'b0;
      if (state == st_fetch) begin
        word_cnt <= word_cnt + 2'd1;
      end
      if (state == st_idle && raster_start) begin
        tri_idx <= '0;
        word_cnt <= '0;
        if (tri_count == 0) begin
          raster_done <= 1'b1;
        end else begin
          state <= st_fetch;
        end
      end else if (tri_end) begin
        word_cnt <= '0;
        if (last_tri) begin
          raster_done <= 1'b1;
          state <= st_idle;
        end else begin
          tri_idx <= tri_idx + 1'b1;
          state <= st_fetch;
        end
      end else if (state == st_fetch && word_cnt == 2'd3) begin
        state <= st_scan;
      end
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (state == st_fetch && word_cnt != 2'd3) begin
      vx[word_cnt] <= tri_rd_data[x_w-1:0];
      vy[word_cnt] <= tri_rd_data[x_w+y_w-1:x_w];
      if (word_cnt == 2'd0) begin
        z0 <= tri_rd_data[x_w+y_w+z_w-1:x_w+y_w];
      end
    end else if (state == st_fetch) begin
      color <= tri_rd_data[rgb_w-1:0];
      bx_min <= (x_lo < 0) ? '0 : x_lo[px_w-1:0];
      bx_max <= (x_hi > screen_w - 1) ? px_w'(screen_w - 1) : x_hi[px_w-1:0];
      by_min <= (y_lo < 0) ? '0 : y_lo[py_w-1:0];
      by_max <= (y_hi > screen_h - 1) ? py_w'(screen_h - 1) : y_hi[py_w-1:0];
      px <= (x_lo < 0) ? '0 : x_lo[px_w-1:0];
      py <= (y_lo < 0) ? '0 : y_lo[py_w-1:0];
    end else if (state == st_scan && step) begin
      if (px == bx_max) begin
        px <= bx_min;
        py <= py + 1'b1;
      end else begin
        px <= px + 1'b1;
      end
    end
  end

  assert property (@(posedge gpu_clk) disable iff (rst_in)
    frag_valid |-> px >= bx_min && px <= bx_max && py >= by_min && py <= by_max);

endmodule

// File: logic/depth_write.sv
`timescale 1ns/1ns

module depth_write import gpu_geom_pkg::*; (
  input  logic gpu_clk,
  input  logic rst_in,
  input  logic frame_start,
  input  logic frag_valid,
  input  frag_t frag_data,
  input  logic dw_gnt,
  input  fb_word_t fb_rd_data,
  output logic frag_ready,
  output logic depth_idle,
  output logic [count_w-1:0] pass_count,
  output logic dw_req,
  output logic dw_we,
  output logic [fb_addr_w-1:0] dw_addr,
  output fb_word_t dw_wdata
);

  localparam int ptr_w = $clog2(frag_q_depth);

  typedef enum logic [1:0] {st_idle, st_read, st_cmp, st_write} dw_state_t;

  dw_state_t state;
  frag_t queue [frag_q_depth];
  frag_t cur;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0] count;
  logic push;
  logic pop;

  assign frag_ready = count != (ptr_w + 1)'(frag_q_depth);
  assign push = frag_valid && frag_ready;
  assign pop = state == st_idle && count != 0;
  assign depth_idle = state == st_idle && count == 0;

  assign dw_req = state == st_read || state == st_write;
  assign dw_we = state == st_write;
  assign dw_addr = {cur.y, cur.x};
  assign dw_wdata = {cur.z, cur.rgb};

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      state <= st_idle;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      pass_count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
      if (frame_start) begin
        pass_count <= '0;
      end else if (state == st_write && dw_gnt) begin
        pass_count <= pass_count + 1'b1;
      end
      case (state)
        st_idle: if (pop) state <= st_read;
        st_read: if (dw_gnt) state <= st_cmp;
        // stored word arrives the cycle after the read grant
        st_cmp: state <= (cur.z < fb_rd_data.z) ? st_write : st_idle;
        default: if (dw_gnt) state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (push) queue[wr_ptr] <= frag_data;
    if (pop) cur <= queue[rd_ptr];
  end

  // a push never lands on an unread entry
  assert property (@(posedge gpu_clk) disable iff (rst_in)
    push |-> count == 0 || wr_ptr != rd_ptr);

endmodule

// File: logic/fb_clear.sv
`timescale 1ns/1ns

module fb_clear import gpu_geom_pkg::*; (
  input  logic gpu_clk,
  input  logic rst_in,
  input  logic clear_start,
  input  logic [rgb_w-1:0] bg_color,
  input  logic clr_gnt,
  output logic clear_done,
  output logic clr_req,
  output logic [fb_addr_w-1:0] clr_addr,
  output fb_word_t clr_wdata
);

  assign clr_wdata = {z_far, bg_color};

  // req stays up for the whole sweep, one address per grant
  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      clr_req <= 1'b0;
      clr_addr <= '0;
      clear_done <= 1'b0;
    end else begin
      clear_done <= 1'b0;
      if (clear_start) begin
        clr_req <= 1'b1;
        clr_addr <= '0;
      end else if (clr_req && clr_gnt) begin
        clr_addr <= clr_addr + 1'b1;
        if (clr_addr == fb_addr_w'(fb_words - 1)) begin
          clr_req <= 1'b0;
          clear_done <= 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/fb_arbiter.sv
`timescale 1ns/1ns

module fb_arbiter import gpu_geom_pkg::*; (
  input  logic gpu_clk,
  input  logic rst_in,
  input  logic clr_req,
  input  logic [fb_addr_w-1:0] clr_addr,
  input  fb_word_t clr_wdata,
  input  logic dw_req,
  input  logic dw_we,
  input  logic [fb_addr_w-1:0] dw_addr,
  input  fb_word_t dw_wdata,
  input  logic host_req,
  input  logic [fb_addr_w-1:0] host_addr,
  output logic clr_gnt,
  output logic dw_gnt,
  output logic host_gnt,
  output fb_word_t fb_rd_data
);

  fb_word_t fb_mem [fb_words];
  logic mem_we;
  logic [fb_addr_w-1:0] mem_addr;
  fb_word_t mem_wdata;

  // clear first, then depth writer, host last
  assign clr_gnt = clr_req;
  assign dw_gnt = dw_req && !clr_req;
  assign host_gnt = host_req && !clr_req && !dw_req;

  always_comb begin
    mem_we = clr_gnt || (dw_gnt && dw_we);
    mem_addr = host_addr;
    mem_wdata = dw_wdata;
    if (clr_gnt) begin
      mem_addr = clr_addr;
      mem_wdata = clr_wdata;
    end else if (dw_gnt) begin
      mem_addr = dw_addr;
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (mem_we) begin
      fb_mem[mem_addr] <= mem_wdata;
    end
    fb_rd_data <= fb_mem[mem_addr];
  end

  // a waiting requester keeps its request and address until granted
  assert property (@(posedge gpu_clk) disable iff (rst_in)
    dw_req && !dw_gnt |=> dw_req && $stable(dw_addr));
  assert property (@(posedge gpu_clk) disable iff (rst_in)
    host_req && !host_gnt |=> host_req && $stable(host_addr));

endmodule

// File: logic/gpu_bus_pkg.sv
package gpu_bus_pkg;

  localparam int axi_addr_w = 12;
  localparam int axi_data_w = 32;
  localparam logic [1:0] resp_okay = 2'b00;

  // register offsets
  localparam logic [axi_addr_w-1:0] ctrl_reg = 12'h000;
  localparam logic [axi_addr_w-1:0] status_reg = 12'h004;
  localparam logic [axi_addr_w-1:0] tri_count_reg = 12'h008;
  localparam logic [axi_addr_w-1:0] bg_color_reg = 12'h00C;
  localparam logic [axi_addr_w-1:0] frame_count_reg = 12'h010;
  localparam logic [axi_addr_w-1:0] pixel_count_reg = 12'h014;

  // memory windows, base plus byte mask of the window
  localparam logic [axi_addr_w-1:0] tri_mem_base = 12'h400;
  localparam logic [axi_addr_w-1:0] tri_win_mask = 12'h0FF;
  localparam logic [axi_addr_w-1:0] fb_base = 12'h800;
  localparam logic [axi_addr_w-1:0] fb_win_mask = 12'h7FF;

endpackage

// File: logic/gpu_geom_pkg.sv
package gpu_geom_pkg;

  // screen and framebuffer
  localparam int screen_w = 32;
  localparam int screen_h = 16;
  localparam int fb_words = 512;
  localparam int fb_addr_w = 9;

  // vertex coordinates are signed so vertices may sit off screen
  localparam int x_w = 6;
  localparam int y_w = 5;
  localparam int z_w = 8;
  localparam int rgb_w = 12;
  localparam logic [z_w-1:0] z_far = 8'd255;

  // triangle memory, three vertex words then one colour word per record
  localparam int max_tris = 16;
  localparam int tri_words = 4;
  localparam int tri_addr_w = 6;
  localparam int tri_word_w = 32;
  localparam int tri_cnt_w = 5;

  localparam int count_w = 16;
  localparam int frag_q_depth = 4;

  typedef struct packed {
    logic [z_w-1:0] z;
    logic [rgb_w-1:0] rgb;
  } fb_word_t;

  typedef struct packed {
    logic [$clog2(screen_w)-1:0] x;
    logic [$clog2(screen_h)-1:0] y;
    logic [z_w-1:0] z;
    logic [rgb_w-1:0] rgb;
  } frag_t;

endpackage
